// File: mem_bus_ctrl.f
logic/mem_bus_pkg.sv
logic/bus_slave_capture.sv
logic/req_latch_pair.sv
logic/mem_port_sequencer.sv
logic/mem_bus_ctrl.sv
bench/sram_model.sv
bench/mem_bus_ctrl_tb.sv

// File: bench/mem_bus_ctrl_tb.sv
// Testbench for the memory-side bus controller with clock, reset, grant model,
// shadow memory, return checker, directed tests and watchdog
`timescale 1ns/10ps
`default_nettype none

module mem_bus_ctrl_tb;
   import mem_bus_pkg::*;

   localparam int CLK_NS      = 20;
   localparam int WATCHDOG_NS = 150 * 60 * CLK_NS;

   logic         bus_clk;
   logic         rst_n;
   logic         cmd_valid;
   bus_cmd_t     cmd;
   logic [31:0]  cmd_data;
   logic         ack;
   logic         br;
   logic         bg;
   logic         ret_valid;
   bus_ret_t     ret;
   mem_port_t    mem_bus;
   logic [255:0] mem_rdata;

   // Expected memory contents with one byte per entry
   logic [7:0]   shadow [0:32767];
   // Expected return beats in issue order
   bus_ret_t     exp_q [$];
   string        cur_test;
   int           grant_delay;
   int           grant_count;
   int           ack_grants;
   int           writes_issued;
   int           writes_done;

   mem_bus_ctrl UUT
   (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .cmd_data  (cmd_data),
      .ack       (ack),
      .br        (br),
      .bg        (bg),
      .ret_valid (ret_valid),
      .ret       (ret),
      .mem       (mem_bus),
      .mem_rdata (mem_rdata)
   );

   sram_model u_sram
   (
      .bus_clk   (bus_clk),
      .mem       (mem_bus),
      .mem_rdata (mem_rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Clock, bus grant and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      bus_clk = 1'b0;
      forever
         #(CLK_NS / 2) bus_clk = ~bus_clk;
   end

   // One-cycle grant after grant_delay cycles of br
   initial
   begin
      bg          = 1'b0;
      grant_count = 0;
      forever
      begin
         @(posedge bus_clk);
         if (br === 1'b1 && bg === 1'b0)
         begin
            repeat (grant_delay)
               @(posedge bus_clk);
            bg <= 1'b1;
            grant_count++;
            @(posedge bus_clk);
            bg <= 1'b0;
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Error reporting and helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic fail_value(input string what, input logic [31:0] want,
                             input logic [31:0] got);
      $display("FAIL %s: %s expected %0h actual %0h", cur_test, what, want, got);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic fail_text(input string msg);
      $display("Error in %s: %s", cur_test, msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   function automatic logic [7:0] power_on_byte(input logic [14:0] a);
      return a[7:0] ^ {a[14:8], 1'b0} ^ 8'ha5;
   endfunction

   function automatic logic [127:0] rand_block();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   // Every return beat is compared with the oldest expected beat
   initial
   begin
      bus_ret_t want;
      forever
      begin
         @(posedge bus_clk);
         if (ret_valid === 1'b1)
         begin
            assert (exp_q.size() != 0)
            else fail_text("a return beat arrived with no read outstanding");
            want = exp_q.pop_front();
            assert (ret.data === want.data)
            else fail_value("return data", want.data, ret.data);
            assert (ret.dest === want.dest)
            else fail_value("return dest", want.dest, ret.dest);
            assert (br === 1'b0)
            else fail_value("br during return", 32'd0, br);
         end
      end
   end

   // Memory write strobes seen on the port
   initial
   begin
      writes_done = 0;
      forever
      begin
         @(negedge bus_clk);
         if (mem_bus.en === 1'b1 && mem_bus.wr === 1'b1)
            writes_done++;
      end
   end

   // Header is held until ack is seen and the task returns at the edge that closes the ack cycle
   task automatic send_header(input logic [15:0] a, input logic rw, input size_t sz,
                              input src_t src);
      @(posedge bus_clk);
      cmd_valid <= 1'b1;
      cmd       <= '{addr: a, rw: rw, size: sz, src: src};
      do
         @(posedge bus_clk);
      while (ack !== 1'b1);
      ack_grants = grant_count;
   endtask

   task automatic bus_write(input logic [15:0] a, input size_t sz, input src_t src,
                            input logic [127:0] data);
      int n;
      n = 1 << int'(sz);
      writes_issued++;
      // First n bytes of the burst land from the line offset upward
      for (int i = 0; i < n; i++)
         shadow[a[14:0] + i] = data[8*i +: 8];
      send_header(a, 1'b1, sz, src);
      for (int k = 0; k < BEATS; k++)
      begin
         if (k > 0)
            @(posedge bus_clk);
         cmd_data <= data[32*k +: 32];
      end
      @(posedge bus_clk);
      cmd_valid <= 1'b0;
   endtask

   task automatic bus_read(input logic [15:0] a, input size_t sz, input src_t src);
      int       base;
      bus_ret_t beat;
      // Addressed 16-byte half with the low word first
      base = {a[14:4], 4'b0000};
      for (int k = 0; k < BEATS; k++)
      begin
         for (int b = 0; b < 4; b++)
            beat.data[8*b +: 8] = shadow[base + 4*k + b];
         beat.dest = 3'b001 << int'(src);
         exp_q.push_back(beat);
      end
      send_header(a, 1'b0, sz, src);
      cmd_valid <= 1'b0;
   endtask

   task automatic wait_idle;
      while (exp_q.size() != 0 || writes_done < writes_issued)
         @(posedge bus_clk);
      assert (writes_done == writes_issued)
      else fail_value("memory write strobes", writes_issued, writes_done);
   endtask

   task automatic check_quiet;
      assert (ack === 1'b0) else fail_value("ack", 32'd0, ack);
      assert (br === 1'b0) else fail_value("br", 32'd0, br);
      assert (ret_valid === 1'b0) else fail_value("ret_valid", 32'd0, ret_valid);
      assert (mem_bus.en === 1'b0) else fail_value("mem.en", 32'd0, mem_bus.en);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic reset_state;
      cur_test = "reset_state";
      for (int c = 0; c < 4; c++)
      begin
         @(posedge bus_clk);
         if (c > 0)
            check_quiet();
      end
      rst_n <= 1'b1;
      repeat (3)
      begin
         @(posedge bus_clk);
         check_quiet();
      end
   endtask

   task automatic full_line_write_read;
      cur_test = "full_line_write_read";
      bus_write(16'h0140, SZ_16, SRC_DC, rand_block());
      bus_write(16'h0150, SZ_16, SRC_DC, rand_block());
      bus_read(16'h0140, SZ_16, SRC_DC);
      bus_read(16'h0150, SZ_16, SRC_DC);
      wait_idle();
   endtask

   task automatic partial_writes;
      cur_test = "partial_writes";
      bus_write(16'h0a63, SZ_1, SRC_DC, rand_block());
      bus_write(16'h0a66, SZ_2, SRC_DMA, rand_block());
      bus_write(16'h0a68, SZ_4, SRC_DC, rand_block());
      bus_write(16'h0a72, SZ_2, SRC_IC, rand_block());
      bus_write(16'h0a78, SZ_8, SRC_DMA, rand_block());
      bus_read(16'h0a60, SZ_16, SRC_DC);
      bus_read(16'h0a70, SZ_16, SRC_DC);
      wait_idle();
   endtask

   task automatic dest_per_source;
      cur_test = "dest_per_source";
      bus_read(16'h0200, SZ_16, SRC_IC);
      bus_read(16'h0214, SZ_4, SRC_DC);
      bus_read(16'h1230, SZ_8, SRC_DMA);
      wait_idle();
   endtask

   task automatic backpressure_order;
      int g0;
      cur_test    = "backpressure_order";
      grant_delay = 40;
      g0          = grant_count;
      bus_read(16'h0300, SZ_16, SRC_DMA);
      bus_write(16'h0300, SZ_16, SRC_DC, rand_block());
      assert (ack_grants == g0)
      else fail_value("grants before write 1 ack", g0, ack_grants);
      // Both latches are full now and the next headers wait for the grant
      bus_write(16'h0310, SZ_16, SRC_DC, rand_block());
      assert (ack_grants == g0 + 1)
      else fail_value("grants before write 2 ack", g0 + 1, ack_grants);
      bus_write(16'h0308, SZ_8, SRC_IC, rand_block());
      assert (ack_grants == g0 + 1)
      else fail_value("grants before write 3 ack", g0 + 1, ack_grants);
      wait_idle();
      grant_delay = 0;
      bus_read(16'h0300, SZ_16, SRC_DC);
      bus_read(16'h0310, SZ_16, SRC_DC);
      wait_idle();
   endtask

   task automatic random_traffic;
      size_t       sz;
      src_t        src;
      logic [15:0] a;
      cur_test = "random_traffic";
      for (int i = 0; i < 40; i++)
      begin
         sz  = size_t'($urandom_range(4, 0));
         src = src_t'($urandom_range(2, 0));
         // Small window so reads often hit written bytes
         a   = 16'($urandom_range(255, 0));
         a   = a & ~16'((1 << int'(sz)) - 1);
         if ($urandom_range(1, 0) == 1)
            bus_write(a, sz, src, rand_block());
         else
            bus_read(a, sz, src);
      end
      wait_idle();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(32'h2fd66b00));
      rst_n         = 1'b0;
      cmd_valid     = 1'b0;
      cmd           = '0;
      cmd_data      = '0;
      grant_delay   = 0;
      ack_grants    = 0;
      writes_issued = 0;
      cur_test      = "setup";
      for (int a = 0; a < 32768; a++)
         shadow[a] = power_on_byte(15'(a));
      reset_state();
      full_line_write_read();
      partial_writes();
      dest_per_source();
      backpressure_order();
      random_traffic();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/sram_model.sv
// Behavioral 1024-line by 32-byte memory with byte enables
// and a read pipeline of MEM_LAT stages
`timescale 1ns/10ps
`default_nettype none

module sram_model
(
   input  logic                   bus_clk,
   input  mem_bus_pkg::mem_port_t mem,
   output logic [255:0]           mem_rdata
);
   import mem_bus_pkg::*;

   logic [LINE_BYTES*8-1:0] lines [0:1023];
   logic [LINE_BYTES*8-1:0] pipe  [0:MEM_LAT-1];

   // Power-on contents, each byte derived from its full byte address
   function automatic logic [7:0] init_byte(input logic [14:0] a);
      return a[7:0] ^ {a[14:8], 1'b0} ^ 8'ha5;
   endfunction

   initial
   begin
      for (int l = 0; l < 1024; l++)
         for (int b = 0; b < LINE_BYTES; b++)
            lines[l][8*b +: 8] = init_byte({l[9:0], b[4:0]});
   end

   always @(posedge bus_clk)
   begin
      if (mem.en && mem.wr)
      begin
         for (int b = 0; b < LINE_BYTES; b++)
            if (mem.be[b])
               lines[mem.addr[14:5]][8*b +: 8] <= mem.wdata[8*b +: 8];
      end
      // Line read enters the pipe every cycle, used only after an en cycle
      pipe[0] <= lines[mem.addr[14:5]];
      for (int i = 1; i < MEM_LAT; i++)
         pipe[i] <= pipe[i-1];
   end

   assign mem_rdata = pipe[MEM_LAT-1];

endmodule

`default_nettype wire

// File: logic/mem_bus_ctrl.sv
// Memory-side bus controller top with capture, latch pair and sequencer
`timescale 1ns/10ps
`default_nettype none

module mem_bus_ctrl
(
   input  logic                   bus_clk,
   input  logic                   rst_n,
   // Requester bus
   input  logic                   cmd_valid,
   input  mem_bus_pkg::bus_cmd_t  cmd,
   input  logic [31:0]            cmd_data,
   output logic                   ack,
   // Arbitration and return
   output logic                   br,
   input  logic                   bg,
   output logic                   ret_valid,
   output mem_bus_pkg::bus_ret_t  ret,
   // Memory array
   output mem_bus_pkg::mem_port_t mem,
   input  logic [255:0]           mem_rdata
);
   import mem_bus_pkg::*;

   logic     wr_full;
   logic     push;
   mem_req_t push_req;
   logic     rd_valid;
   mem_req_t rd_req;
   logic     rd_done;

   bus_slave_capture u_capture
   (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .cmd_data  (cmd_data),
      .wr_full   (wr_full),
      .ack       (ack),
      .push      (push),
      .push_req  (push_req)
   );

   req_latch_pair u_latches
   (
      .bus_clk  (bus_clk),
      .rst_n    (rst_n),
      .push     (push),
      .push_req (push_req),
      .rd_done  (rd_done),
      .wr_full  (wr_full),
      .rd_valid (rd_valid),
      .rd_req   (rd_req)
   );

   mem_port_sequencer u_sequencer
   (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .rd_valid  (rd_valid),
      .rd_req    (rd_req),
      .rd_done   (rd_done),
      .mem       (mem),
      .mem_rdata (mem_rdata),
      .br        (br),
      .bg        (bg),
      .ret_valid (ret_valid),
      .ret       (ret)
   );

endmodule

`default_nettype wire

// File: logic/mem_port_sequencer.sv
// Memory access sequencer with write data alignment, read latency wait
// and bus-master return of the read half-line
`timescale 1ns/10ps
`default_nettype none

module mem_port_sequencer
(
   input  logic                   bus_clk,
   input  logic                   rst_n,
   input  logic                   rd_valid,
   input  mem_bus_pkg::mem_req_t  rd_req,
   output logic                   rd_done,
   output mem_bus_pkg::mem_port_t mem,
   input  logic [255:0]           mem_rdata,
   output logic                   br,
   input  logic                   bg,
   output logic                   ret_valid,
   output mem_bus_pkg::bus_ret_t  ret
);
   import mem_bus_pkg::*;

   typedef enum logic [2:0]
   {
      IDLE,
      ACCESS,
      WAIT_MEM,
      REQ_BUS,
      RETURN
   } state_t;

   state_t              state;
   logic [1:0]          lat_cnt;
   logic [1:0]          beat_cnt;
   logic [BEATS*32-1:0] rdata_q;
   logic [BEATS*32-1:0] wdata_shift;
   logic [15:0]         be_shift;
   logic                hi_half;
   logic                mem_ready;

   // Byte enables of a transfer before alignment
   function automatic logic [15:0] size_mask(input size_t sz);
      case (sz)
         SZ_1:    size_mask = 16'h0001;
         SZ_2:    size_mask = 16'h0003;
         SZ_4:    size_mask = 16'h000f;
         SZ_8:    size_mask = 16'h00ff;
         SZ_16:   size_mask = 16'hffff;
         default: size_mask = 16'h0000;
      endcase
   endfunction

   function automatic logic [2:0] src_dest(input src_t src);
      case (src)
         SRC_IC:  src_dest = 3'b001;
         SRC_DC:  src_dest = 3'b010;
         SRC_DMA: src_dest = 3'b100;
         default: src_dest = 3'b000;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////////////////////////////////////////

   assign mem_ready = (state == WAIT_MEM) && (lat_cnt == 2'(MEM_LAT - 1));

   always_ff @(posedge bus_clk)
   begin
      if (!rst_n)
      begin
         state    <= IDLE;
         lat_cnt  <= '0;
         beat_cnt <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (rd_valid)
                  state <= ACCESS;
            end
            ACCESS:
            begin
               lat_cnt <= '0;
               state   <= WAIT_MEM;
            end
            WAIT_MEM:
            begin
               // Writes retire one cycle after the memory strobe
               if (rd_req.rw)
                  state <= IDLE;
               else if (mem_ready)
                  state <= REQ_BUS;
               else
                  lat_cnt <= lat_cnt + 2'd1;
            end
            REQ_BUS:
            begin
               beat_cnt <= '0;
               if (bg)
                  state <= RETURN;
            end
            RETURN:
            begin
               beat_cnt <= beat_cnt + 2'd1;
               if (beat_cnt == 2'(BEATS - 1))
                  state <= IDLE;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Memory port
   ////////////////////////////////////////////////////////////////////////////

   assign hi_half     = rd_req.addr[4];
   assign wdata_shift = rd_req.data << {rd_req.addr[3:0], 3'b000};
   assign be_shift    = size_mask(rd_req.size) << rd_req.addr[3:0];

   always_comb
   begin
      mem.addr  = rd_req.addr[14:0];
      mem.en    = (state == ACCESS);
      mem.wr    = (state == ACCESS) && rd_req.rw;
      mem.be    = hi_half ? {be_shift, 16'h0000} : {16'h0000, be_shift};
      mem.wdata = hi_half ? {wdata_shift, {BEATS*32{1'b0}}}
                          : {{BEATS*32{1'b0}}, wdata_shift};
   end

   // Keep only the addressed half of the line
   always_ff @(posedge bus_clk)
   begin
      if (mem_ready && !rd_req.rw)
         rdata_q <= hi_half ? mem_rdata[255:128] : mem_rdata[127:0];
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus return
   ////////////////////////////////////////////////////////////////////////////

   assign br        = (state == REQ_BUS);
   assign ret_valid = (state == RETURN);
   assign ret       = '{data: rdata_q[{beat_cnt, 5'b00000} +: 32],
                        dest: src_dest(rd_req.src)};

   assign rd_done = ((state == WAIT_MEM) && rd_req.rw) ||
                    ((state == RETURN) && (beat_cnt == 2'(BEATS - 1)));

endmodule

`default_nettype wire

// File: logic/req_latch_pair.sv
// Two-entry request buffer made of a write latch feeding a read latch
`timescale 1ns/10ps
`default_nettype none

module req_latch_pair
(
   input  logic                  bus_clk,
   input  logic                  rst_n,
   input  logic                  push,
   input  mem_bus_pkg::mem_req_t push_req,
   input  logic                  rd_done,
   output logic                  wr_full,
   output logic                  rd_valid,
   output mem_bus_pkg::mem_req_t rd_req
);
   import mem_bus_pkg::*;

   mem_req_t wr_q;
   mem_req_t rd_q;
   logic     wr_v;
   logic     rd_v;
   logic     move;

   // Forward when the read latch is empty or being freed this cycle
   assign move = wr_v && (!rd_v || rd_done);

   always_ff @(posedge bus_clk)
   begin
      if (!rst_n)
      begin
         wr_v <= 1'b0;
         rd_v <= 1'b0;
      end
      else
      begin
         // push only arrives with the write latch empty
         if (push)
            wr_v <= 1'b1;
         else if (move)
            wr_v <= 1'b0;

         if (move)
            rd_v <= 1'b1;
         else if (rd_done)
            rd_v <= 1'b0;
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (push)
         wr_q <= push_req;
      if (move)
         rd_q <= wr_q;
   end

   assign wr_full  = wr_v;
   assign rd_valid = rd_v;
   assign rd_req   = rd_q;

endmodule

`default_nettype wire

// File: logic/bus_slave_capture.sv
// Bus slave front end that acknowledges headers, gathers write beats
// and pushes one request into the latch pair
`timescale 1ns/10ps
`default_nettype none

module bus_slave_capture
(
   input  logic                  bus_clk,
   input  logic                  rst_n,
   input  logic                  cmd_valid,
   input  mem_bus_pkg::bus_cmd_t cmd,
   input  logic [31:0]           cmd_data,
   input  logic                  wr_full,
   output logic                  ack,
   output logic                  push,
   output mem_bus_pkg::mem_req_t push_req
);
   import mem_bus_pkg::*;

   typedef enum logic [1:0]
   {
      IDLE,
      ACK,
      DATA,
      PUSH
   } state_t;

   state_t              state;
   bus_cmd_t            hdr;
   logic [BEATS*32-1:0] data;
   logic [1:0]          beat_cnt;
   logic                take_hdr;

   // A header is taken only when the write latch has room
   assign take_hdr = (state == IDLE) && cmd_valid && !wr_full;

   always_ff @(posedge bus_clk)
   begin
      if (!rst_n)
      begin
         state    <= IDLE;
         beat_cnt <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (take_hdr)
                  state <= ACK;
            end
            ACK:
            begin
               beat_cnt <= '0;
               state    <= hdr.rw ? DATA : PUSH;
            end
            DATA:
            begin
               beat_cnt <= beat_cnt + 2'd1;
               if (beat_cnt == 2'(BEATS - 1))
                  state <= PUSH;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Header and write data
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge bus_clk)
   begin
      if (take_hdr)
         hdr <= cmd;
      // Low word arrives first and ends up at the bottom
      if (state == ACK)
         data <= '0;
      else if (state == DATA)
         data <= {cmd_data, data[BEATS*32-1:32]};
   end

   assign ack  = (state == ACK);
   assign push = (state == PUSH);

   assign push_req = '{addr: hdr.addr, rw: hdr.rw, size: hdr.size, src: hdr.src,
                       data: data};

endmodule

`default_nettype wire

// File: logic/mem_bus_pkg.sv
// Shared bus formats, request and memory-port structs, size and source codes,
// and the fixed transfer constants of the memory-side bus controller
`default_nettype none

package mem_bus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Fixed sizes of the bus format
   ////////////////////////////////////////////////////////////////////////////

   // 32-bit data beats per transfer
   localparam int BEATS      = 4;
   // Cycles from the mem_en cycle to valid read data
   localparam int MEM_LAT    = 2;
   localparam int LINE_BYTES = 32;

   ////////////////////////////////////////////////////////////////////////////
   // Codes
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0]
   {
      SRC_IC,
      SRC_DC,
      SRC_DMA
   } src_t;

   // Transfer size in bytes, log2 coded
   typedef enum logic [2:0]
   {
      SZ_1,
      SZ_2,
      SZ_4,
      SZ_8,
      SZ_16
   } size_t;

   ////////////////////////////////////////////////////////////////////////////
   // Structs
   ////////////////////////////////////////////////////////////////////////////

   // Header beat from a requester, rw high for a write
   typedef struct packed
   {
      logic [15:0] addr;
      logic        rw;
      size_t       size;
      src_t        src;
   } bus_cmd_t;

   // One buffered request, write data low word first
   typedef struct packed
   {
      logic [15:0]         addr;
      logic                rw;
      size_t               size;
      src_t                src;
      logic [BEATS*32-1:0] data;
   } mem_req_t;

   typedef struct packed
   {
      logic [14:0]             addr;
      logic                    en;
      logic                    wr;
      logic [LINE_BYTES-1:0]   be;
      logic [LINE_BYTES*8-1:0] wdata;
   } mem_port_t;

   // Return beat, dest one-hot as {DMA, DC, IC}
   typedef struct packed
   {
      logic [31:0] data;
      logic [2:0]  dest;
   } bus_ret_t;

endpackage

`default_nettype wire
